// File: Makefile
VERILATOR ?= verilator
TOP_TB    ?= tb_psg
FILELIST  ?= psg.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP_TB)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP_TB) \
		--Mdir $(BUILD_DIR) -o V$(TOP_TB)
	./$(BUILD_DIR)/V$(TOP_TB) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: psg.f
psg_pkg.sv
psg_regs.sv
psg_tone.sv
psg_noise.sv
psg_envelope.sv
psg_mixer.sv
psg.sv
psg_checker.sv
tb_psg.sv

// File: psg.sv
`timescale 1ns/100ps

module psg (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        a0,
    input  logic                        wren,
    input  logic [7:0]                  wrdata,
    output logic [7:0]                  rddata,

    input  logic [7:0]                  ioa_in_data,
    output logic [7:0]                  ioa_out_data,
    output logic                        ioa_oe,

    input  logic [7:0]                  iob_in_data,
    output logic [7:0]                  iob_out_data,
    output logic                        iob_oe,

    output logic [psg_pkg::LEVEL_W-1:0] ch_a,
    output logic [psg_pkg::LEVEL_W-1:0] ch_b,
    output logic [psg_pkg::LEVEL_W-1:0] ch_c
);
    import psg_pkg::*;

    logic [TONE_W-1:0]  a_period;
    logic [TONE_W-1:0]  b_period;
    logic [TONE_W-1:0]  c_period;
    logic [NOISE_W-1:0] noise_period;
    logic [2:0]         tone_n;
    logic [2:0]         noise_n;
    logic [4:0]         a_volume;
    logic [4:0]         b_volume;
    logic [4:0]         c_volume;
    logic [ENV_W-1:0]   env_period;
    logic               env_continue;
    logic               env_attack;
    logic               env_alternate;
    logic               env_hold;
    logic               shape_wr;
    logic               tick;
    logic [2:0]         tone;
    logic               noise;
    logic [3:0]         env_level;

    //////////////////////////////
    // Bus side
    //////////////////////////////
    psg_regs regs_i (
        .clk, .reset, .a0, .wren, .wrdata, .rddata,
        .ioa_in_data, .ioa_out_data, .ioa_oe,
        .iob_in_data, .iob_out_data, .iob_oe,
        .a_period, .b_period, .c_period, .noise_period,
        .tone_n, .noise_n, .a_volume, .b_volume, .c_volume,
        .env_period, .env_continue, .env_attack, .env_alternate, .env_hold,
        .shape_wr
    );

    //////////////////////////////
    // Sound generators
    //////////////////////////////
    psg_tone tone_i (
        .clk, .reset, .a_period, .b_period, .c_period, .tick, .tone
    );

    psg_noise noise_i (
        .clk, .reset, .tick, .noise_period, .noise
    );

    psg_envelope envelope_i (
        .clk, .reset, .tick, .env_period,
        .env_continue, .env_attack, .env_alternate, .env_hold,
        .shape_wr, .env_level
    );

    psg_mixer mixer_i (
        .clk, .reset, .tick, .tone, .noise, .tone_n, .noise_n,
        .a_volume, .b_volume, .c_volume, .env_level,
        .ch_a, .ch_b, .ch_c
    );

endmodule

// File: psg_checker.sv
`timescale 1ns/100ps

module psg_checker (
    input  logic [7:0]                  rddata,
    input  logic [7:0]                  ioa_out_data,
    input  logic                        ioa_oe,
    input  logic [7:0]                  iob_out_data,
    input  logic                        iob_oe,
    input  logic [psg_pkg::LEVEL_W-1:0] ch_a,
    input  logic [psg_pkg::LEVEL_W-1:0] ch_b,
    input  logic [psg_pkg::LEVEL_W-1:0] ch_c
);
    import psg_pkg::*;

    int    test_count   = 0;
    int    failed_tests = 0;
    int    check_count  = 0;
    int    error_count  = 0;
    int    test_errors  = 0;
    string test_name    = "none";

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic compare(input string signal, input logic [31:0] actual,
                           input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch %s in %s: got 0x%0h, expected 0x%0h",
                     signal, test_name, actual, expected);
            test_errors++;
            error_count++;
        end
    endtask

    // Failures that are not a wrong value, such as a wait running out
    task automatic report_failure(input string what);
        $display("error in %s: %s", test_name, what);
        test_errors++;
        error_count++;
    endtask

    task automatic check_rddata(input logic [7:0] expected);
        compare("rddata", 32'(rddata), 32'(expected));
    endtask

    task automatic check_port_a(input logic [7:0] data, input logic oe);
        compare("ioa_oe", 32'(ioa_oe), 32'(oe));
        compare("ioa_out_data", 32'(ioa_out_data), 32'(data));
    endtask

    task automatic check_port_b(input logic [7:0] data, input logic oe);
        compare("iob_oe", 32'(iob_oe), 32'(oe));
        compare("iob_out_data", 32'(iob_out_data), 32'(data));
    endtask

    // Volume indices go through the log table
    task automatic check_levels(input logic [3:0] ia, input logic [3:0] ib,
                                input logic [3:0] ic);
        compare("ch_a", 32'(ch_a), 32'(LEVEL_TABLE[ia]));
        compare("ch_b", 32'(ch_b), 32'(LEVEL_TABLE[ib]));
        compare("ch_c", 32'(ch_c), 32'(LEVEL_TABLE[ic]));
    endtask

    task automatic end_test();
        test_count++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", test_count, test_name, test_errors);
        end
    endtask

    task automatic print_summary();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
    endtask

endmodule

// File: psg_envelope.sv
`timescale 1ns/100ps

module psg_envelope (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      tick,
    input  logic [psg_pkg::ENV_W-1:0] env_period,
    input  logic                      env_continue,
    input  logic                      env_attack,
    input  logic                      env_alternate,
    input  logic                      env_hold,
    input  logic                      shape_wr,
    output logic [3:0]                env_level
);
    import psg_pkg::*;

    logic [ENV_W:0] period_cnt;
    logic           period_done;
    logic           step;
    logic [3:0]     cnt;
    logic [3:0]     cnt_next;
    logic           count_up;
    logic           up_next;
    logic           restart_pending;
    env_state_e     state;
    env_state_e     state_next;

    // Step interval is twice the programmed period
    assign period_done = period_cnt >= {env_period, 1'b0};
    assign step        = tick && period_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            period_cnt <= '0;
        end else if (tick) begin
            period_cnt <= period_done ? '0 : period_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Shape sequencing
    //////////////////////////////
    always_comb begin
        cnt_next   = cnt;
        up_next    = count_up;
        state_next = state;
        if (restart_pending) begin
            cnt_next   = 4'd15;
            up_next    = env_attack;
            state_next = ENV_RUN;
        end else if (state == ENV_RUN) begin
            cnt_next = cnt - 4'd1;
            // End of a ramp
            if (cnt == 4'd0) begin
                if (!env_continue || env_hold) begin
                    cnt_next   = 4'd0;
                    state_next = ENV_STOP;
                end
                if ((env_continue && env_alternate) || (!env_continue && env_attack)) begin
                    up_next = !count_up;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt             <= 4'd0;
            count_up        <= 1'b0;
            state           <= ENV_RUN;
            env_level       <= 4'd0;
            restart_pending <= 1'b0;
        end else begin
            if (step) begin
                cnt             <= cnt_next;
                count_up        <= up_next;
                state           <= state_next;
                env_level       <= up_next ? ~cnt_next : cnt_next;
                restart_pending <= 1'b0;
            end
            // A shape write in the same cycle as a step stays pending
            if (shape_wr) begin
                restart_pending <= 1'b1;
            end
        end
    end

    a_stop_holds: assert property (@(posedge clk) disable iff (reset)
        (state == ENV_STOP && !restart_pending) |=> $stable(env_level))
        else $error("envelope level moved while stopped");

endmodule

// File: psg_mixer.sv
`timescale 1ns/100ps

module psg_mixer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        tick,
    input  logic [2:0]                  tone,
    input  logic                        noise,
    input  logic [2:0]                  tone_n,
    input  logic [2:0]                  noise_n,
    input  logic [4:0]                  a_volume,
    input  logic [4:0]                  b_volume,
    input  logic [4:0]                  c_volume,
    input  logic [3:0]                  env_level,
    output logic [psg_pkg::LEVEL_W-1:0] ch_a,
    output logic [psg_pkg::LEVEL_W-1:0] ch_b,
    output logic [psg_pkg::LEVEL_W-1:0] ch_c
);
    import psg_pkg::*;

    logic [2:0]              chan_on;
    logic [2:0][4:0]         volume;
    logic [2:0][3:0]         index;
    logic [2:0][LEVEL_W-1:0] level_q;

    // A disabled source counts as always high
    assign chan_on = (tone | tone_n) & ({3{noise}} | noise_n);
    assign volume  = {c_volume, b_volume, a_volume};

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (!chan_on[i]) begin
                index[i] = 4'd0;
            end else if (volume[i][4]) begin
                index[i] = env_level;
            end else begin
                index[i] = volume[i][3:0];
            end
        end
    end

    // Log level lookup, sampled once per tick
    always_ff @(posedge clk) begin
        if (reset) begin
            level_q <= '0;
        end else if (tick) begin
            for (int i = 0; i < 3; i++) begin
                level_q[i] <= LEVEL_TABLE[index[i]];
            end
        end
    end

    assign ch_a = level_q[0];
    assign ch_b = level_q[1];
    assign ch_c = level_q[2];

endmodule

// File: psg_noise.sv
`timescale 1ns/100ps

module psg_noise (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        tick,
    input  logic [psg_pkg::NOISE_W-1:0] noise_period,
    output logic                        noise
);
    import psg_pkg::*;

    logic [NOISE_W-1:0] count;
    logic               prescale;
    logic [16:0]        lfsr;

    assign noise = lfsr[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            prescale <= 1'b0;
            lfsr     <= 17'd1;
        end else if (tick) begin
            if (count >= noise_period) begin
                count    <= '0;
                prescale <= !prescale;
                // Shift only on every second wrap
                if (prescale) begin
                    lfsr <= {lfsr[0] ^ lfsr[3], lfsr[16:1]};
                end
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    a_lfsr_live: assert property (@(posedge clk) disable iff (reset)
        lfsr != '0)
        else $error("noise LFSR locked at zero");

endmodule

// File: psg_pkg.sv
package psg_pkg;

    // Datapath widths
    localparam int TONE_W   = 12;
    localparam int NOISE_W  = 5;
    localparam int ENV_W    = 16;
    localparam int LEVEL_W  = 10;

    // Clocks per sound tick
    localparam int TICK_DIV = 128;

    // Register map as seen through the byte bus
    typedef enum logic [3:0] {
        REG_A_FINE     = 4'h0,
        REG_A_COARSE   = 4'h1,
        REG_B_FINE     = 4'h2,
        REG_B_COARSE   = 4'h3,
        REG_C_FINE     = 4'h4,
        REG_C_COARSE   = 4'h5,
        REG_NOISE      = 4'h6,
        REG_ENABLE     = 4'h7,
        REG_A_VOL      = 4'h8,
        REG_B_VOL      = 4'h9,
        REG_C_VOL      = 4'hA,
        REG_ENV_FINE   = 4'hB,
        REG_ENV_COARSE = 4'hC,
        REG_ENV_SHAPE  = 4'hD,
        REG_PORT_A     = 4'hE,
        REG_PORT_B     = 4'hF
    } psg_reg_e;

    typedef enum logic {
        ENV_RUN  = 1'b0,
        ENV_STOP = 1'b1
    } env_state_e;

    // Roughly 3 dB per volume step, full scale at index 15
    localparam logic [LEVEL_W-1:0] LEVEL_TABLE [16] = '{
        10'd0,   10'd6,   10'd9,   10'd13,  10'd19,  10'd27,  10'd39,  10'd56,
        10'd80,  10'd116, 10'd166, 10'd239, 10'd344, 10'd495, 10'd712, 10'd1023
    };

endpackage

// File: psg_regs.sv
`timescale 1ns/100ps

module psg_regs (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        a0,
    input  logic                        wren,
    input  logic [7:0]                  wrdata,
    output logic [7:0]                  rddata,

    input  logic [7:0]                  ioa_in_data,
    output logic [7:0]                  ioa_out_data,
    output logic                        ioa_oe,
    input  logic [7:0]                  iob_in_data,
    output logic [7:0]                  iob_out_data,
    output logic                        iob_oe,

    output logic [psg_pkg::TONE_W-1:0]  a_period,
    output logic [psg_pkg::TONE_W-1:0]  b_period,
    output logic [psg_pkg::TONE_W-1:0]  c_period,
    output logic [psg_pkg::NOISE_W-1:0] noise_period,
    output logic [2:0]                  tone_n,
    output logic [2:0]                  noise_n,
    output logic [4:0]                  a_volume,
    output logic [4:0]                  b_volume,
    output logic [4:0]                  c_volume,

    output logic [psg_pkg::ENV_W-1:0]   env_period,
    output logic                        env_continue,
    output logic                        env_attack,
    output logic                        env_alternate,
    output logic                        env_hold,
    output logic                        shape_wr
);
    import psg_pkg::*;

    psg_reg_e reg_addr;
    logic     data_wr;

    assign data_wr  = wren && !a0;
    assign shape_wr = data_wr && (reg_addr == REG_ENV_SHAPE);

    // Address phase
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_addr <= REG_A_FINE;
        end else if (wren && a0) begin
            reg_addr <= psg_reg_e'(wrdata[3:0]);
        end
    end

    //////////////////////////////
    // Register file
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            a_period      <= '0;
            b_period      <= '0;
            c_period      <= '0;
            noise_period  <= '0;
            tone_n        <= 3'b111;
            noise_n       <= 3'b111;
            ioa_oe        <= 1'b0;
            iob_oe        <= 1'b0;
            a_volume      <= '0;
            b_volume      <= '0;
            c_volume      <= '0;
            env_period    <= '0;
            env_continue  <= 1'b0;
            env_attack    <= 1'b0;
            env_alternate <= 1'b0;
            env_hold      <= 1'b0;
            ioa_out_data  <= '0;
            iob_out_data  <= '0;
        end else if (data_wr) begin
            case (reg_addr)
                REG_A_FINE:     a_period[7:0]         <= wrdata;
                REG_A_COARSE:   a_period[TONE_W-1:8]  <= wrdata[TONE_W-9:0];
                REG_B_FINE:     b_period[7:0]         <= wrdata;
                REG_B_COARSE:   b_period[TONE_W-1:8]  <= wrdata[TONE_W-9:0];
                REG_C_FINE:     c_period[7:0]         <= wrdata;
                REG_C_COARSE:   c_period[TONE_W-1:8]  <= wrdata[TONE_W-9:0];
                REG_NOISE:      noise_period          <= wrdata[NOISE_W-1:0];
                // Enables are active low, port directions high for output
                REG_ENABLE:     {iob_oe, ioa_oe, noise_n, tone_n} <= wrdata;
                REG_A_VOL:      a_volume              <= wrdata[4:0];
                REG_B_VOL:      b_volume              <= wrdata[4:0];
                REG_C_VOL:      c_volume              <= wrdata[4:0];
                REG_ENV_FINE:   env_period[7:0]       <= wrdata;
                REG_ENV_COARSE: env_period[ENV_W-1:8] <= wrdata[ENV_W-9:0];
                REG_ENV_SHAPE: begin
                    {env_continue, env_attack, env_alternate, env_hold} <= wrdata[3:0];
                end
                REG_PORT_A:     ioa_out_data          <= wrdata;
                REG_PORT_B:     iob_out_data          <= wrdata;
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // Readback
    //////////////////////////////
    always_comb begin
        case (reg_addr)
            REG_A_FINE:     rddata = a_period[7:0];
            REG_A_COARSE:   rddata = 8'(a_period[TONE_W-1:8]);
            REG_B_FINE:     rddata = b_period[7:0];
            REG_B_COARSE:   rddata = 8'(b_period[TONE_W-1:8]);
            REG_C_FINE:     rddata = c_period[7:0];
            REG_C_COARSE:   rddata = 8'(c_period[TONE_W-1:8]);
            REG_NOISE:      rddata = 8'(noise_period);
            REG_ENABLE:     rddata = {iob_oe, ioa_oe, noise_n, tone_n};
            REG_A_VOL:      rddata = 8'(a_volume);
            REG_B_VOL:      rddata = 8'(b_volume);
            REG_C_VOL:      rddata = 8'(c_volume);
            REG_ENV_FINE:   rddata = env_period[7:0];
            REG_ENV_COARSE: rddata = 8'(env_period[ENV_W-1:8]);
            REG_ENV_SHAPE:  rddata = {4'b0, env_continue, env_attack, env_alternate, env_hold};
            // Ports read the pins unless driven
            REG_PORT_A:     rddata = ioa_oe ? ioa_out_data : ioa_in_data;
            REG_PORT_B:     rddata = iob_oe ? iob_out_data : iob_in_data;
            default:        rddata = 8'h00;
        endcase
    end

    a_wrdata_known: assert property (@(posedge clk) disable iff (reset)
        wren |-> !$isunknown(wrdata))
        else $error("wrdata unknown during a bus write");

endmodule

// File: psg_tone.sv
`timescale 1ns/100ps

module psg_tone (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [psg_pkg::TONE_W-1:0] a_period,
    input  logic [psg_pkg::TONE_W-1:0] b_period,
    input  logic [psg_pkg::TONE_W-1:0] c_period,
    output logic                       tick,
    output logic [2:0]                 tone
);
    import psg_pkg::*;

    localparam int DIV_W = $clog2(TICK_DIV);

    logic [DIV_W-1:0]       div;
    logic [2:0][TONE_W-1:0] period;
    logic [2:0][TONE_W-1:0] count;

    assign period = {c_period, b_period, a_period};
    assign tick   = (div == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            div   <= '0;
            count <= '0;
            tone  <= '0;
        end else begin
            div <= (div == DIV_W'(TICK_DIV - 1)) ? '0 : div + 1'b1;
            if (tick) begin
                // Period counts 0..P so each half wave lasts P+1 ticks
                for (int i = 0; i < 3; i++) begin
                    if (count[i] >= period[i]) begin
                        count[i] <= '0;
                        tone[i]  <= !tone[i];
                    end else begin
                        count[i] <= count[i] + 1'b1;
                    end
                end
            end
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (reset)
        tick |=> !tick)
        else $error("tick high on consecutive clocks");

endmodule

// File: tb_psg.sv
`timescale 1ns/100ps

module tb_psg;
    import psg_pkg::*;

    localparam int RANDOM_WRITES = 64;
    localparam int TICK_TIMEOUT  = TICK_DIV + 4;
    localparam int ENV_TIMEOUT   = 64 * 3 * TICK_DIV;
    localparam int HOLD_CLOCKS   = 16 * TICK_DIV;
    localparam int RUN_LIMIT_NS  = 2_000_000;

    logic               clk = 1'b0;
    logic               reset;
    logic               a0;
    logic               wren;
    logic [7:0]         wrdata;
    logic [7:0]         rddata;
    logic [7:0]         ioa_in_data;
    logic [7:0]         ioa_out_data;
    logic               ioa_oe;
    logic [7:0]         iob_in_data;
    logic [7:0]         iob_out_data;
    logic               iob_oe;
    logic [LEVEL_W-1:0] ch_a;
    logic [LEVEL_W-1:0] ch_b;
    logic [LEVEL_W-1:0] ch_c;

    integer     seed = 32'hb53;
    logic [7:0] reg_model [16];

    always #5 clk = ~clk;

    psg psg_i (
        .clk, .reset, .a0, .wren, .wrdata, .rddata,
        .ioa_in_data, .ioa_out_data, .ioa_oe,
        .iob_in_data, .iob_out_data, .iob_oe,
        .ch_a, .ch_b, .ch_c
    );

    psg_checker checker_i (
        .rddata, .ioa_out_data, .ioa_oe, .iob_out_data, .iob_oe,
        .ch_a, .ch_b, .ch_c
    );

    //////////////////////////////
    // Register model
    //////////////////////////////
    function automatic logic [7:0] reg_mask(input psg_reg_e r);
        case (r)
            REG_A_COARSE, REG_B_COARSE, REG_C_COARSE: return 8'h0F;
            REG_NOISE, REG_A_VOL, REG_B_VOL, REG_C_VOL: return 8'h1F;
            REG_ENV_SHAPE: return 8'h0F;
            default: return 8'hFF;
        endcase
    endfunction

    // Ports read back the pins while the direction bit is clear
    function automatic logic [7:0] expected_read(input psg_reg_e r);
        case (r)
            REG_PORT_A: return reg_model[REG_ENABLE][6] ? reg_model[REG_PORT_A] : ioa_in_data;
            REG_PORT_B: return reg_model[REG_ENABLE][7] ? reg_model[REG_PORT_B] : iob_in_data;
            default:    return reg_model[r];
        endcase
    endfunction

    function automatic logic [7:0] random_byte();
        logic [31:0] value;
        value = $random(seed);
        return value[7:0];
    endfunction

    //////////////////////////////
    // Bus and wait tasks
    //////////////////////////////
    task automatic bus_cycle(input logic addr_phase, input logic [7:0] data);
        @(negedge clk);
        a0     = addr_phase;
        wren   = 1'b1;
        wrdata = data;
        @(negedge clk);
        wren   = 1'b0;
    endtask

    task automatic write_reg(input psg_reg_e r, input logic [7:0] data);
        bus_cycle(1'b1, 8'(r));
        bus_cycle(1'b0, data);
        reg_model[r] = data & reg_mask(r);
    endtask

    task automatic wait_levels(input logic [3:0] ia, input logic [3:0] ib,
                               input logic [3:0] ic, output bit reached);
        int clocks;
        clocks  = 0;
        reached = 1'b0;
        while (!reached && clocks < TICK_TIMEOUT) begin
            @(negedge clk);
            clocks++;
            reached = (ch_a == LEVEL_TABLE[ia]) && (ch_b == LEVEL_TABLE[ib])
                      && (ch_c == LEVEL_TABLE[ic]);
        end
    endtask

    task automatic wait_a_change(input int limit, output int clocks, output bit changed);
        logic [LEVEL_W-1:0] start;
        start   = ch_a;
        clocks  = 0;
        changed = 1'b0;
        while (!changed && clocks < limit) begin
            @(negedge clk);
            clocks++;
            changed = (ch_a != start);
        end
    endtask

    task automatic wait_a_level(input logic [LEVEL_W-1:0] target, input int limit,
                                output bit reached);
        int clocks;
        clocks  = 0;
        reached = (ch_a == target);
        while (!reached && clocks < limit) begin
            @(negedge clk);
            clocks++;
            reached = (ch_a == target);
        end
    endtask

    // Hard stop in case the sequence below never ends
    initial begin
        #(RUN_LIMIT_NS);
        $display("run stopped after %0d ns without finishing", RUN_LIMIT_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [7:0]         vol [3];
        logic [7:0]         rnd;
        logic [LEVEL_W-1:0] expected_level;
        int                 period;
        int                 clocks;
        bit                 ok;
        bit                 held;
        psg_reg_e           r;

        reset       = 1'b1;
        a0          = 1'b0;
        wren        = 1'b0;
        wrdata      = 8'h00;
        ioa_in_data = random_byte();
        iob_in_data = random_byte();
        for (int i = 0; i < 16; i++) begin
            reg_model[i] = 8'h00;
        end
        reg_model[REG_ENABLE] = 8'h3F;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        checker_i.begin_test("reset values");
        checker_i.check_levels(4'd0, 4'd0, 4'd0);
        checker_i.check_port_a(reg_model[REG_PORT_A], 1'b0);
        checker_i.check_port_b(reg_model[REG_PORT_B], 1'b0);
        for (int i = 0; i < 16; i++) begin
            r = psg_reg_e'(4'(i));
            bus_cycle(1'b1, 8'(r));
            checker_i.check_rddata(expected_read(r));
        end
        checker_i.end_test();

        checker_i.begin_test("random readback");
        for (int n = 0; n < RANDOM_WRITES; n++) begin
            rnd = random_byte();
            r   = psg_reg_e'(rnd[3:0]);
            write_reg(r, random_byte());
            checker_i.check_rddata(expected_read(r));
        end
        checker_i.end_test();

        checker_i.begin_test("io ports");
        write_reg(REG_ENABLE, 8'hFF);
        write_reg(REG_PORT_A, random_byte());
        checker_i.check_port_a(reg_model[REG_PORT_A], 1'b1);
        checker_i.check_rddata(expected_read(REG_PORT_A));
        write_reg(REG_PORT_B, random_byte());
        checker_i.check_port_b(reg_model[REG_PORT_B], 1'b1);
        checker_i.check_rddata(expected_read(REG_PORT_B));
        write_reg(REG_ENABLE, 8'h3F);
        for (int i = 0; i < 8; i++) begin
            r = i[0] ? REG_PORT_B : REG_PORT_A;
            bus_cycle(1'b1, 8'(r));
            ioa_in_data = random_byte();
            iob_in_data = random_byte();
            @(negedge clk);
            checker_i.check_rddata(expected_read(r));
        end
        checker_i.end_test();

        // Tone and noise off, so every channel is on at its volume
        checker_i.begin_test("fixed levels");
        for (int i = 0; i < 3; i++) begin
            vol[i] = random_byte() & 8'h0F;
        end
        write_reg(REG_A_VOL, vol[0]);
        write_reg(REG_B_VOL, vol[1]);
        write_reg(REG_C_VOL, vol[2]);
        wait_levels(vol[0][3:0], vol[1][3:0], vol[2][3:0], ok);
        if (!ok) begin
            checker_i.report_failure("channel levels did not settle within one tick");
        end
        checker_i.check_levels(vol[0][3:0], vol[1][3:0], vol[2][3:0]);
        checker_i.end_test();

        //////////////////////////////
        // Square wave on channel A
        //////////////////////////////
        checker_i.begin_test("tone period");
        period = 1 + ($random(seed) & 3);
        write_reg(REG_A_FINE, 8'(period));
        write_reg(REG_A_COARSE, 8'h00);
        write_reg(REG_A_VOL, 8'h0F);
        write_reg(REG_ENABLE, 8'h3E);
        // Two edges to get past the old counter state
        for (int i = 0; i < 2; i++) begin
            wait_a_change((period + 3) * TICK_DIV, clocks, ok);
        end
        for (int i = 0; i < 3; i++) begin
            expected_level = (ch_a == '0) ? LEVEL_TABLE[15] : '0;
            wait_a_change((period + 3) * TICK_DIV, clocks, ok);
            if (!ok) begin
                checker_i.report_failure("channel A stopped toggling");
            end else begin
                checker_i.compare("tone interval", 32'(clocks), 32'((period + 1) * TICK_DIV));
                checker_i.compare("ch_a", 32'(ch_a), 32'(expected_level));
            end
        end
        checker_i.end_test();

        //////////////////////////////
        // Attack then hold at full scale
        //////////////////////////////
        checker_i.begin_test("envelope hold");
        write_reg(REG_ENABLE, 8'h3F);
        write_reg(REG_ENV_FINE, 8'h01);
        write_reg(REG_ENV_COARSE, 8'h00);
        write_reg(REG_A_VOL, 8'h10);
        write_reg(REG_ENV_SHAPE, 8'h0D);
        wait_a_level('0, 8 * TICK_DIV, ok);
        if (!ok) begin
            checker_i.report_failure("envelope did not restart at level 0");
        end
        wait_a_level(LEVEL_TABLE[15], ENV_TIMEOUT, ok);
        if (!ok) begin
            checker_i.report_failure("envelope never reached full scale");
        end else begin
            held = 1'b1;
            for (int i = 0; i < HOLD_CLOCKS && held; i++) begin
                @(negedge clk);
                held = (ch_a == LEVEL_TABLE[15]);
            end
            checker_i.compare("ch_a", 32'(ch_a), 32'(LEVEL_TABLE[15]));
        end
        checker_i.end_test();

        checker_i.print_summary();
        if (checker_i.error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
